// File: source/cart_load_pkg.sv
// Widths, host index codes, enums and structs shared by the cart loader
`default_nettype none

package cart_load_pkg;

	// ====================================================================
	// Widths and constants
	// ====================================================================
	localparam int dl_addr_w  = 25; // Host byte address
	localparam int rom_addr_w = 24; // ROM write address
	localparam int map_addr_w = 22; // CPU read address and size masks
	localparam int hdr_size   = 512; // Optional copier header in front of the image

	// Host index codes
	localparam logic [7:0] cheat_index = 8'hff;
	localparam logic [7:0] gg_index    = 8'd2; // Handheld cartridge

	// ====================================================================
	// Enums
	// ====================================================================
	typedef enum logic [1:0] {
		dl_none  = 2'd0,
		dl_cart  = 2'd1,
		dl_cheat = 2'd2
	} dl_kind_e;

	typedef enum logic {
		sys_sms = 1'b0,
		sys_gg  = 1'b1
	} cart_sys_e;

	// Four-phase handshake of the ROM writer
	typedef enum logic [1:0] {
		wr_idle         = 2'd0,
		wr_req_high     = 2'd1, // Waiting for ack to rise
		wr_ack_low_wait = 2'd2  // Req dropped, waiting for ack to fall
	} wr_state_e;

	// ====================================================================
	// Structs
	// ====================================================================
	// One registered host write, tagged with its kind
	typedef struct packed {
		dl_kind_e               kind;
		logic [dl_addr_w-1:0]   addr;
		logic [7:0]             data;
		cart_sys_e              sys;
		logic                   valid;
		logic                   start; // First cycle of a download
		logic                   done;  // First cycle after a download
	} dl_beat_t;

	typedef struct packed {
		logic [rom_addr_w-1:0]  addr;
		logic [7:0]             data;
	} mem_wr_t;

	// Cheat record, each field little endian on the host stream
	typedef struct packed {
		logic [31:0]            flags;
		logic [31:0]            address;
		logic [31:0]            compare;
		logic [31:0]            replace;
	} cheat_code_t;

endpackage

`default_nettype wire

// File: source/dl_classifier.sv
// Host download front end: input registers, kind decode and start/done edges
`default_nettype none

module dl_classifier (
	input  wire                                  clk_sys,
	input  wire                                  arst_n,
	input  wire                                  dl_active,
	input  wire [7:0]                            dl_index,
	input  wire [cart_load_pkg::dl_addr_w-1:0]   dl_addr,
	input  wire [7:0]                            dl_data,
	input  wire                                  dl_wr,
	output cart_load_pkg::dl_beat_t              beat
);

	logic                                act_q; // dl_active one cycle ago
	logic                                valid_q;
	logic                                start_q;
	logic                                done_q;
	cart_load_pkg::dl_kind_e             kind_d;
	cart_load_pkg::dl_kind_e             kind_q;
	cart_load_pkg::cart_sys_e            sys_d;
	cart_load_pkg::cart_sys_e            sys_q;
	logic [cart_load_pkg::dl_addr_w-1:0] addr_q;
	logic [7:0]                          data_q;

	// Index decode, only meaningful while a download runs
	always_comb begin
		kind_d = cart_load_pkg::dl_none;
		if (dl_active) begin
			kind_d = (dl_index == cart_load_pkg::cheat_index) ?
				cart_load_pkg::dl_cheat : cart_load_pkg::dl_cart;
		end
		sys_d = (dl_index == cart_load_pkg::gg_index) ?
			cart_load_pkg::sys_gg : cart_load_pkg::sys_sms;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			act_q   <= 1'b0;
			valid_q <= 1'b0;
			start_q <= 1'b0;
			done_q  <= 1'b0;
			kind_q  <= cart_load_pkg::dl_none;
			sys_q   <= cart_load_pkg::sys_sms;
		end else begin
			act_q   <= dl_active;
			valid_q <= dl_wr;
			start_q <= dl_active & ~act_q; // Rising edge
			done_q  <= ~dl_active & act_q; // Falling edge
			kind_q  <= kind_d;
			sys_q   <= sys_d;
		end
	end

	always_ff @(posedge clk_sys) begin
		addr_q <= dl_addr;
		data_q <= dl_data;
	end

	always_comb begin
		beat.kind  = kind_q;
		beat.addr  = addr_q;
		beat.data  = data_q;
		beat.sys   = sys_q;
		beat.valid = valid_q;
		beat.start = start_q;
		beat.done  = done_q;
	end

endmodule

`default_nettype wire

// File: source/cart_rom_writer.sv
// Cartridge ROM writer: address counter, four-phase req/ack and host wait
`default_nettype none

module cart_rom_writer (
	input  wire                        clk_sys,
	input  wire                        arst_n,
	input  wire cart_load_pkg::dl_beat_t beat,
	output logic                       mem_req,
	output cart_load_pkg::mem_wr_t     mem_wr,
	input  wire                        mem_ack,
	output logic                       dl_wait
);

	cart_load_pkg::wr_state_e             state;
	logic [cart_load_pkg::rom_addr_w-1:0] wr_cnt; // Next ROM address
	logic                                 cart_beat;
	logic                                 wr_done;

	assign cart_beat = beat.valid && (beat.kind == cart_load_pkg::dl_cart);

	// Handshake complete once ack is seen low again
	assign wr_done = (state == cart_load_pkg::wr_ack_low_wait) && !mem_ack;

	// ====================================================================
	// Handshake FSM
	// ====================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= cart_load_pkg::wr_idle;
		end else begin
			case (state)
				cart_load_pkg::wr_idle: begin
					if (cart_beat)
						state <= cart_load_pkg::wr_req_high;
				end
				cart_load_pkg::wr_req_high: begin
					if (mem_ack)
						state <= cart_load_pkg::wr_ack_low_wait; // Drop req
				end
				cart_load_pkg::wr_ack_low_wait: begin
					if (!mem_ack)
						state <= cart_load_pkg::wr_idle;
				end
				default: state <= cart_load_pkg::wr_idle;
			endcase
		end
	end

	// Write address, restarts with every download
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_cnt <= '0;
		end else if (beat.start) begin
			wr_cnt <= '0;
		end else if (wr_done) begin
			wr_cnt <= wr_cnt + 1'b1;
		end
	end

	// Payload held for the whole handshake
	always_ff @(posedge clk_sys) begin
		if ((state == cart_load_pkg::wr_idle) && cart_beat) begin
			mem_wr.addr <= beat.start ? '0 : wr_cnt; // First byte may share the start cycle
			mem_wr.data <= beat.data;
		end
	end

	assign mem_req = (state == cart_load_pkg::wr_req_high);
	assign dl_wait = (state != cart_load_pkg::wr_idle); // Host held off until ack falls

endmodule

`default_nettype wire

// File: source/cart_geometry.sv
// Cartridge size masks, header flag, system type and CPU read-address mapping
`default_nettype none

module cart_geometry (
	input  wire                                  clk_sys,
	input  wire                                  arst_n,
	input  wire cart_load_pkg::dl_beat_t         beat,
	input  wire [cart_load_pkg::map_addr_w-1:0]  rd_addr,
	output logic [cart_load_pkg::map_addr_w-1:0] rd_map,
	output cart_load_pkg::cart_sys_e             cart_sys
);

	logic [cart_load_pkg::map_addr_w-1:0] mask;     // Plain image
	logic [cart_load_pkg::map_addr_w-1:0] mask_hdr; // Image behind a header
	logic [cart_load_pkg::map_addr_w-1:0] beat_addr;
	logic [cart_load_pkg::map_addr_w-1:0] addr_less_hdr;
	logic [cart_load_pkg::dl_addr_w-1:0]  size_next; // Bytes loaded so far
	logic                                 size_bit9;
	logic                                 hdr_flag;
	logic                                 cart_beat;

	assign cart_beat     = beat.valid && (beat.kind == cart_load_pkg::dl_cart);
	assign beat_addr     = beat.addr[cart_load_pkg::map_addr_w-1:0];
	assign addr_less_hdr = beat_addr - cart_load_pkg::map_addr_w'(cart_load_pkg::hdr_size);
	assign size_next     = beat.addr + 1'b1;

	// ====================================================================
	// Mask and flag tracking
	// ====================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			mask      <= '0;
			mask_hdr  <= '0;
			size_bit9 <= 1'b0;
			hdr_flag  <= 1'b0;
			cart_sys  <= cart_load_pkg::sys_sms;
		end else begin
			if (cart_beat) begin
				// Each mask restarts at its own first image byte
				if (beat.addr == '0)
					mask <= '0;
				else
					mask <= mask | beat_addr;

				if (beat.addr == cart_load_pkg::dl_addr_w'(cart_load_pkg::hdr_size))
					mask_hdr <= '0;
				else
					mask_hdr <= mask_hdr | addr_less_hdr;

				size_bit9 <= size_next[9];
				cart_sys  <= beat.sys;
			end

			// Image sizes are multiples of 1K, an odd 512 means a header
			if (beat.done)
				hdr_flag <= size_bit9;
		end
	end

	// Read mapping, skips the header and mirrors small images
	always_comb begin
		if (hdr_flag)
			rd_map = (rd_addr + cart_load_pkg::map_addr_w'(cart_load_pkg::hdr_size)) & mask_hdr;
		else
			rd_map = rd_addr & mask;
	end

endmodule

`default_nettype wire

// File: source/cheat_code_assembler.sv
// Cheat record assembly from 16 host bytes with a one-cycle valid pulse
`default_nettype none

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          arst_n,
	input  wire cart_load_pkg::dl_beat_t beat,
	output cart_load_pkg::cheat_code_t   code,
	output logic                         code_valid
);

	// ====================================================================
	// Byte placement
	// ====================================================================
	// Byte n lands in field n/4 (flags first) at byte lane n%4.
	// Flags sit in the top word of the record, so the field number is
	// inverted to get the word offset.

	logic [127:0] code_q;
	logic [6:0]   byte_pos; // Bit offset of the byte in the record
	logic         cheat_beat;
	logic         last_byte;

	assign cheat_beat = beat.valid && (beat.kind == cart_load_pkg::dl_cheat);
	assign last_byte  = (beat.addr[3:0] == 4'hf);
	assign byte_pos   = {~beat.addr[3:2], beat.addr[1:0], 3'b000};

	always_ff @(posedge clk_sys) begin
		if (cheat_beat)
			code_q[byte_pos +: 8] <= beat.data;
	end

	// Pulses together with the last byte landing in code_q
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= cheat_beat && last_byte;
		end
	end

	assign code = cart_load_pkg::cheat_code_t'(code_q);

endmodule

`default_nettype wire

// File: source/cart_loader_top.sv
// Cart loader top level: classifier, ROM writer, geometry and cheat assembler
`default_nettype none

module cart_loader_top (
	input  wire                                  clk_sys,
	input  wire                                  arst_n,

	// Host download stream
	input  wire                                  dl_active,
	input  wire [7:0]                            dl_index,
	input  wire [cart_load_pkg::dl_addr_w-1:0]   dl_addr,
	input  wire [7:0]                            dl_data,
	input  wire                                  dl_wr,
	output logic                                 dl_wait,

	// ROM write port
	output logic                                 mem_req,
	output cart_load_pkg::mem_wr_t               mem_wr,
	input  wire                                  mem_ack,

	// CPU read mapping
	input  wire [cart_load_pkg::map_addr_w-1:0]  rd_addr,
	output logic [cart_load_pkg::map_addr_w-1:0] rd_map,
	output cart_load_pkg::cart_sys_e             cart_sys,

	// Cheat record
	output cart_load_pkg::cheat_code_t           code,
	output logic                                 code_valid
);

	cart_load_pkg::dl_beat_t beat; // Shared by all three back stages

	dl_classifier i_classifier (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wr     (dl_wr),
		.beat      (beat)
	);

	cart_rom_writer i_rom_writer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.beat    (beat),
		.mem_req (mem_req),
		.mem_wr  (mem_wr),
		.mem_ack (mem_ack),
		.dl_wait (dl_wait)
	);

	cart_geometry i_geometry (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.beat     (beat),
		.rd_addr  (rd_addr),
		.rd_map   (rd_map),
		.cart_sys (cart_sys)
	);

	cheat_code_assembler i_cheat (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.beat       (beat),
		.code       (code),
		.code_valid (code_valid)
	);

endmodule

`default_nettype wire

// File: verification/cart_loader_properties.sv
// Four-phase handshake assertions for the ROM writer and their bind
`default_nettype none

module cart_loader_properties (
	input  wire                          clk_sys,
	input  wire                          arst_n,
	input  wire                          mem_req,
	input  wire cart_load_pkg::mem_wr_t  mem_wr,
	input  wire                          mem_ack,
	input  wire                          dl_wait
);

	timeunit 1ns;
	timeprecision 100ps;

	int assert_fail_cnt = 0; // Failed assertions so far

	// Req stays up until ack has been seen
	req_held_for_ack: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(mem_req && !mem_ack) |=> mem_req)
		else begin
			$error("mem_req dropped before mem_ack rose");
			assert_fail_cnt++;
		end

	payload_stable: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_req |=> (!mem_req || $stable(mem_wr)))
		else begin
			$error("mem_wr changed while mem_req was high");
			assert_fail_cnt++;
		end

	wait_covers_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem_req |-> dl_wait)
		else begin
			$error("dl_wait low during a ROM write");
			assert_fail_cnt++;
		end

	// Previous ack must be gone before the next request
	no_req_over_ack: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(mem_req) |-> !$past(mem_ack))
		else begin
			$error("mem_req rose while mem_ack was still high");
			assert_fail_cnt++;
		end

endmodule

bind cart_rom_writer cart_loader_properties i_properties (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.mem_req (mem_req),
	.mem_wr  (mem_wr),
	.mem_ack (mem_ack),
	.dl_wait (dl_wait)
);

`default_nettype wire

// File: verification/cart_loader_tb.sv
// Cart loader testbench with clock, reset, memory model, directed tests, compares and summary
`default_nettype none

module cart_loader_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// About twice the cycles that all tests need together
	localparam int cycle_limit = 40000;

	logic                                 clk_sys;
	logic                                 arst_n;
	logic                                 dl_active;
	logic [7:0]                           dl_index;
	logic [cart_load_pkg::dl_addr_w-1:0]  dl_addr;
	logic [7:0]                           dl_data;
	logic                                 dl_wr;
	logic                                 dl_wait;
	logic                                 mem_req;
	cart_load_pkg::mem_wr_t               mem_wr;
	logic                                 mem_ack;
	logic [cart_load_pkg::map_addr_w-1:0] rd_addr;
	logic [cart_load_pkg::map_addr_w-1:0] rd_map;
	cart_load_pkg::cart_sys_e             cart_sys;
	cart_load_pkg::cheat_code_t           code;
	logic                                 code_valid;

	logic [31:0]                 lcg_state = 32'd46;
	logic [7:0]                  sent[$];       // Bytes of the current download
	int                          ack_delays[$]; // Ack delay per expected write
	cart_load_pkg::mem_wr_t      wr_log[$];     // Writes seen by the memory
	cart_load_pkg::cheat_code_t  code_seen;
	int                          valid_pulses = 0;
	int                          err_cnt = 0;
	int                          tests_run = 0;
	int                          tests_failed = 0;
	int                          cycles = 0;

	cart_loader_top i_dut (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.dl_wr      (dl_wr),
		.dl_wait    (dl_wait),
		.mem_req    (mem_req),
		.mem_wr     (mem_wr),
		.mem_ack    (mem_ack),
		.rd_addr    (rd_addr),
		.rd_map     (rd_map),
		.cart_sys   (cart_sys),
		.code       (code),
		.code_valid (code_valid)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ====================================================================
	// Memory model and monitors
	// ====================================================================
	initial begin : memory_model
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				delay = (ack_delays.size() > 0) ? ack_delays.pop_front() : 0;
				repeat (delay) @(negedge clk_sys);
				wr_log.push_back(mem_wr);
				mem_ack = 1'b1;
			end else if (!mem_req && mem_ack) begin
				mem_ack = 1'b0; // Last phase of the handshake
			end
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid) begin
			valid_pulses++;
			code_seen = code;
		end
	end

	initial begin : watchdog
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles, a test never finished", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ====================================================================
	// Compare tasks
	// ====================================================================
	task automatic wr_compare(input string name, input cart_load_pkg::mem_wr_t got,
			input cart_load_pkg::mem_wr_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got addr %h data %h, expected addr %h data %h",
				name, got.addr, got.data, exp.addr, exp.data);
			err_cnt++;
		end
	endtask

	task automatic code_compare(input string name, input cart_load_pkg::cheat_code_t got,
			input cart_load_pkg::cheat_code_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic sys_compare(input string name, input cart_load_pkg::cart_sys_e got,
			input cart_load_pkg::cart_sys_e exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic map_compare(input string name,
			input logic [cart_load_pkg::map_addr_w-1:0] got,
			input logic [cart_load_pkg::map_addr_w-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic bit_compare(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[FAIL] %s got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// ====================================================================
	// Host driver
	// ====================================================================
	// Single write followed by two idle cycles and a wait on dl_wait
	task automatic host_write(input int addr, input logic [7:0] data);
		dl_addr = cart_load_pkg::dl_addr_w'(addr);
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		repeat (2) @(negedge clk_sys);
		while (dl_wait) @(negedge clk_sys);
	endtask

	task automatic run_download(input logic [7:0] index, input int nbytes, input int delay_max);
		logic [31:0] r;
		int i;
		sent.delete();
		wr_log.delete();
		ack_delays.delete();
		for (i = 0; i < nbytes; i++) begin
			r = lcg_next();
			sent.push_back(r[15:8]);
			ack_delays.push_back((delay_max > 0) ? int'(r[23:16]) % (delay_max + 1) : 0);
		end
		dl_index  = index;
		dl_active = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (i = 0; i < nbytes; i++)
			host_write(i, sent[i]);
		dl_active = 1'b0;
		repeat (3) @(negedge clk_sys); // Let done reach the header flag
	endtask

	// Each sent byte in order at its own address
	task automatic verify_cart_writes();
		cart_load_pkg::mem_wr_t exp;
		int i;
		if (wr_log.size() != sent.size()) begin
			$display("Memory saw %0d writes for %0d bytes sent", wr_log.size(), sent.size());
			err_cnt++;
		end
		for (i = 0; i < sent.size() && i < wr_log.size(); i++) begin
			exp.addr = cart_load_pkg::rom_addr_w'(i);
			exp.data = sent[i];
			wr_compare($sformatf("mem_wr[%0d]", i), wr_log[i], exp);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt == err_before) begin
			$display("Test %-14s ok", name);
		end else begin
			tests_failed++;
			$display("Test %-14s failed with %0d errors", name, err_cnt - err_before);
		end
	endtask

	// ====================================================================
	// Directed tests
	// ====================================================================
	task automatic reset_test();
		int e0;
		e0 = err_cnt;
		bit_compare("mem_req", mem_req, 1'b0);
		bit_compare("dl_wait", dl_wait, 1'b0);
		bit_compare("code_valid", code_valid, 1'b0);
		sys_compare("cart_sys", cart_sys, cart_load_pkg::sys_sms);
		rd_addr = 22'h2a5a5a;
		@(negedge clk_sys);
		map_compare("rd_map", rd_map, '0); // Masks start empty
		report_test("reset", e0);
	endtask

	task automatic cart_write_test();
		int e0;
		e0 = err_cnt;
		run_download(8'd1, 300, 0);
		verify_cart_writes();
		report_test("cart_write", e0);
	endtask

	task automatic back_pressure_test();
		int e0;
		e0 = err_cnt;
		run_download(8'd1, 200, 5);
		verify_cart_writes();
		report_test("back_pressure", e0);
	endtask

	// Plain mask first and then an image with a copier header
	task automatic geometry_test();
		logic [cart_load_pkg::map_addr_w-1:0] mask;
		logic [cart_load_pkg::map_addr_w-1:0] hmask;
		logic [cart_load_pkg::map_addr_w-1:0] exp;
		logic [31:0] r;
		logic [31:0] nbytes;
		int e0;
		int pass;
		int a;
		int k;
		e0 = err_cnt;
		for (pass = 0; pass < 2; pass++) begin
			nbytes = (pass == 0) ? 32'd2048 : 32'd2560;
			run_download(8'd1, nbytes, 0);
			mask  = '0;
			hmask = '0;
			for (a = 0; a < nbytes; a++)
				mask = mask | cart_load_pkg::map_addr_w'(a);
			for (a = cart_load_pkg::hdr_size; a < nbytes; a++)
				hmask = hmask | cart_load_pkg::map_addr_w'(a - cart_load_pkg::hdr_size);
			for (k = 0; k < 8; k++) begin
				r = lcg_next();
				rd_addr = r[cart_load_pkg::map_addr_w-1:0];
				@(negedge clk_sys);
				// Whole kilobytes plus 512 means a header in front
				if (nbytes[9])
					exp = (rd_addr + cart_load_pkg::map_addr_w'(cart_load_pkg::hdr_size)) & hmask;
				else
					exp = rd_addr & mask;
				map_compare($sformatf("rd_map(%h)", rd_addr), rd_map, exp);
			end
		end
		report_test("geometry", e0);
	endtask

	task automatic cheat_code_test();
		cart_load_pkg::cheat_code_t exp;
		int e0;
		int i;
		e0 = err_cnt;
		valid_pulses = 0;
		run_download(cart_load_pkg::cheat_index, 16, 0);
		exp = '0;
		for (i = 0; i < 16; i++) begin
			case (i / 4) // Four fields with the low byte first
				0: exp.flags[8*(i%4) +: 8]   = sent[i];
				1: exp.address[8*(i%4) +: 8] = sent[i];
				2: exp.compare[8*(i%4) +: 8] = sent[i];
				default: exp.replace[8*(i%4) +: 8] = sent[i];
			endcase
		end
		if (valid_pulses != 1) begin
			$display("code_valid pulsed %0d times instead of once", valid_pulses);
			err_cnt++;
		end
		code_compare("code", code_seen, exp);
		if (wr_log.size() != 0) begin
			$display("Cheat download wrote %0d bytes to memory", wr_log.size());
			err_cnt++;
		end
		report_test("cheat_code", e0);
	endtask

	task automatic system_flag_test();
		int e0;
		e0 = err_cnt;
		run_download(cart_load_pkg::gg_index, 4, 0);
		sys_compare("cart_sys", cart_sys, cart_load_pkg::sys_gg);
		run_download(8'd1, 4, 0);
		sys_compare("cart_sys", cart_sys, cart_load_pkg::sys_sms);
		report_test("system_flag", e0);
	endtask

	initial begin : main
		int assert_fails;
		arst_n    = 1'b0;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_addr   = '0;
		dl_data   = '0;
		dl_wr     = 1'b0;
		rd_addr   = '0;
		repeat (4) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		reset_test();
		cart_write_test();
		back_pressure_test();
		geometry_test();
		cheat_code_test();
		system_flag_test();
		assert_fails = i_dut.i_rom_writer.i_properties.assert_fail_cnt;
		$display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, err_cnt, assert_fails);
		if (err_cnt == 0 && assert_fails == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
source/cart_load_pkg.sv
source/dl_classifier.sv
source/cart_rom_writer.sv
source/cart_geometry.sv
source/cheat_code_assembler.sv
source/cart_loader_top.sv
verification/cart_loader_properties.sv
verification/cart_loader_tb.sv
